/* test/l15_vectors.txt */
// First line: memory word count, operation count; then memory words from address 0
// Operation lines: ctrl (bit 3 store, bits 2:0 funct3), address, store data, expected load
0000000C 0000001A
00000013 00100093 00200113 00308193
8899AABB 11F2E3D4 7F80FF01 C0FFEE42
00000000 00000000 DEADBEEF 0000006F
// Byte loads at every offset of the doubleword
0 00000010 00000000 FFFFFFBB
4 00000011 00000000 000000AA
0 00000012 00000000 FFFFFF99
4 00000013 00000000 00000088
0 00000014 00000000 FFFFFFD4
0 00000015 00000000 FFFFFFE3
4 00000016 00000000 000000F2
0 00000017 00000000 00000011
// Halfword and word loads
1 00000010 00000000 FFFFAABB
5 00000012 00000000 00008899
1 00000014 00000000 FFFFE3D4
5 00000016 00000000 000011F2
1 0000001A 00000000 00007F80
2 00000010 00000000 8899AABB
2 0000001C 00000000 C0FFEE42
// Stores read back
A 00000020 12345678 00000000
2 00000020 00000000 12345678
8 00000025 000000A5 00000000
0 00000025 00000000 FFFFFFA5
9 00000022 0000BEEF 00000000
2 00000020 00000000 BEEF5678
// Misaligned, memory left unchanged
1 00000011 00000000 00000000
2 0000002A 00000000 00000000
A 00000026 99999999 00000000
2 00000024 00000000 0000A500
2 00000028 00000000 DEADBEEF

/* build.f */
+incdir+include
design/l15_pkg.sv
design/load_extract.sv
design/fetch_unit.sv
design/data_access_unit.sv
design/port_arbiter.sv
design/l15_core_port.sv
test/tb_l15_core_port.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module tb_l15_core_port -o tb_sim
out=$(./obj_dir/tb_sim 2>&1) || true
echo "$out"
echo "$out" | grep -q "Everything OK"

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Fetched pc and instruction against the memory model
task automatic check_fetch(input l15_pkg::fetch_out_t got, input l15_pkg::fetch_out_t want);
	if (got !== want)
		fail_run($sformatf("[FAIL] %0t: fetch pc %h instr %h, expected pc %h instr %h",
			$time, got.pc, got.instr, want.pc, want.instr));
endtask

// Load data and misaligned flag of a finished operation
task automatic check_result(input l15_pkg::mem_result_t got,
	input l15_pkg::mem_result_t want);
	if (got !== want)
		fail_run($sformatf("[FAIL] %0t: result data %h misaligned %b, expected %h %b",
			$time, got.load_data, got.misaligned, want.load_data, want.misaligned));
endtask

// Header fields of a request on the port
task automatic check_request(input l15_pkg::l15_req_t got, input l15_pkg::l15_req_t want);
	if (got.rqtype !== want.rqtype || got.size !== want.size ||
		got.address !== want.address || got.val !== want.val)
		fail_run({$sformatf("[FAIL] %0t: request type %h size %h addr %h val %b,",
			$time, got.rqtype, got.size, got.address, got.val),
			$sformatf(" expected %h %h %h %b",
			want.rqtype, want.size, want.address, want.val)});
endtask

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

`endif

/* test/tb_l15_core_port.sv */
`timescale 1ns/1ps

module tb_l15_core_port;

	localparam l15_pkg::xlen_t RESET_PC = 32'h0000_0008;
	localparam int MEM_WORDS = 1024;

	logic clk;
	logic nrst;
	l15_pkg::l15_rsp_t port_rsp;
	logic header_ack;
	logic ack;
	l15_pkg::mem_op_t mem_op;
	logic mem_valid;
	l15_pkg::l15_req_t port_req;
	logic req_ack;
	logic mem_ready;
	logic mem_done;
	l15_pkg::mem_result_t mem_result;
	logic fetch_valid;
	l15_pkg::fetch_out_t fetch;

	logic [31:0] vec [0:255];
	logic [31:0] mem [0:MEM_WORDS-1];
	logic [31:0] rng;
	int n_ops;
	int fetch_count;
	l15_pkg::xlen_t exp_pc;
	l15_pkg::fetch_out_t exp_fetch;

	// Model state: 0 idle, 1 header wait, 2 response wait, 3 response on port
	int mstate;
	int hold;
	l15_pkg::l15_req_t cur_req;
	l15_pkg::l15_req_t exp_req;
	logic exp_req_valid;

	l15_core_port #(
		.RESET_PC(RESET_PC)
	) UUT (.*);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	`include "tb_checks.svh"

	// Port delay of 0 to 3 cycles
	function automatic int draw_delay();
		rng = xorshift(rng);
		return int'(rng[1:0]);
	endfunction

	function automatic l15_pkg::dword_t read_dword(input l15_pkg::xlen_t a);
		logic [9:0] w;
		w = {a[11:3], 1'b0};
		return {mem[w + 10'd1], mem[w]};
	endfunction

	// Size and address pick the bytes, data lanes give their values
	task automatic write_store(input l15_pkg::l15_req_t r);
		int nbytes;
		int k;
		logic [2:0] b;
		logic [9:0] w;
		logic [31:0] word;
		nbytes = (r.size == l15_pkg::SIZE_BYTE) ? 1 : (r.size == l15_pkg::SIZE_HALF) ? 2 : 4;
		for (k = 0; k < nbytes; k++)
		begin
			b = r.address[2:0] + 3'(k);
			w = {r.address[11:3], b[2]};
			word = mem[w];
			word[8*b[1:0] +: 8] = r.data[8*b +: 8];
			mem[w] = word;
		end
	endtask

	// Natural alignment by access size
	function automatic logic misaligned_op(input l15_pkg::mem_op_t o);
		case (o.funct3[1:0])
			2'b00: return 1'b0;
			2'b01: return o.address[0];
			default: return |o.address[1:0];
		endcase
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// L1.5 memory model
	initial
	begin
		port_rsp = '0;
		header_ack = 1'b0;
		ack = 1'b0;
		rng = 32'd93;
		mstate = 0;
		hold = 0;
		forever
		begin
			@(negedge clk);
			if (nrst === 1'b1)
			begin
				if (port_rsp.val)
				begin
					port_rsp.val = 1'b0;
					mstate = 0;
				end
				if (mstate == 0 && port_req.val)
				begin
					cur_req = port_req;
					if (cur_req.rqtype != l15_pkg::RQ_IFILL)
					begin
						if (!exp_req_valid)
							fail_run("Data request on the port with no aligned operation pending");
						check_request(cur_req, exp_req);
						exp_req_valid = 1'b0;
					end
					hold = draw_delay();
					mstate = 1;
				end
				if (mstate == 1)
				begin
					if (header_ack)
					begin
						// Header taken at the last rising edge
						header_ack = 1'b0;
						hold = draw_delay();
						mstate = 2;
					end
					else if (!port_req.val)
						mstate = 0;
					else
					begin
						check_request(port_req, cur_req);
						if (hold == 0)
							header_ack = 1'b1;
						else
							hold--;
					end
				end
				if (mstate == 2)
				begin
					if (port_req.val)
						fail_run("A second request appeared while one was outstanding");
					if (hold == 0)
					begin
						port_rsp.data_0.raw = read_dword(cur_req.address);
						if (cur_req.rqtype == l15_pkg::RQ_IFILL)
							port_rsp.returntype = l15_pkg::RT_IFILL;
						else if (cur_req.rqtype == l15_pkg::RQ_STORE)
							port_rsp.returntype = l15_pkg::RT_STORE_ACK;
						else
							port_rsp.returntype = l15_pkg::RT_LOAD;
						if (cur_req.rqtype == l15_pkg::RQ_STORE)
							write_store(cur_req);
						port_rsp.val = 1'b1;
						mstate = 3;
						#1;
						if (!req_ack)
							fail_run("req_ack stayed low while a response was on the port");
					end
					else
						hold--;
				end
			end
		end
	end

	// Fetch stream in pc order
	initial
	begin
		fetch_count = 0;
		exp_pc = RESET_PC;
		forever
		begin
			@(negedge clk);
			if (nrst === 1'b1 && fetch_valid)
			begin
				exp_fetch.pc = exp_pc;
				exp_fetch.instr = mem[exp_pc[11:2]];
				check_fetch(fetch, exp_fetch);
				exp_pc = exp_pc + 32'd4;
				fetch_count++;
			end
		end
	end

	initial
	begin
		wait (nrst === 1'b1);
		repeat (n_ops * 40 + 2000) @(posedge clk);
		fail_run("Timeout: the operations did not finish in time");
	end

	initial
	begin
		l15_pkg::mem_op_t op;
		l15_pkg::mem_result_t exp_res;
		l15_pkg::xlen_t a;
		int i;
		int m;
		int base;
		int seen;
		nrst = 1'b0;
		mem_op = '0;
		mem_valid = 1'b0;
		exp_req = '0;
		exp_req_valid = 1'b0;
		for (i = 0; i < MEM_WORDS; i++)
		begin
			a = 32'(i) << 2;
			mem[i] = {~a[15:0], a[15:0]};
		end
		$readmemh("test/l15_vectors.txt", vec);
		m = int'(vec[0]);
		n_ops = int'(vec[1]);
		for (i = 0; i < m; i++)
			mem[i] = vec[2 + i];
		base = 2 + m;
		repeat (8) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		for (i = 0; i < n_ops; i++)
		begin
			op.is_store = vec[base + 4 * i][3];
			op.funct3 = vec[base + 4 * i][2:0];
			op.address = vec[base + 4 * i + 1];
			op.store_data = vec[base + 4 * i + 2];
			exp_res.load_data = vec[base + 4 * i + 3];
			exp_res.misaligned = misaligned_op(op);
			while (!mem_ready)
				@(negedge clk);
			exp_req.rqtype = op.is_store ? l15_pkg::RQ_STORE : l15_pkg::RQ_LOAD;
			exp_req.size = (op.funct3[1:0] == 2'b00) ? l15_pkg::SIZE_BYTE :
				(op.funct3[1:0] == 2'b01) ? l15_pkg::SIZE_HALF : l15_pkg::SIZE_WORD;
			exp_req.address = op.address;
			exp_req.val = 1'b1;
			exp_req_valid = !exp_res.misaligned;
			mem_op = op;
			mem_valid = 1'b1;
			@(negedge clk);
			mem_valid = 1'b0;
			while (!mem_done)
				@(negedge clk);
			check_result(mem_result, exp_res);
			if (exp_req_valid)
				fail_run("Operation completed without sending its request");
			// Fetch has to pick up again once the port is free
			seen = fetch_count;
			while (fetch_count == seen)
				@(negedge clk);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

/* design/l15_core_port.sv */
`timescale 1ns/1ps

module l15_core_port #(
	parameter l15_pkg::xlen_t RESET_PC = 32'h0000_0000
) (
	input logic clk,
	input logic nrst,
	input l15_pkg::l15_rsp_t port_rsp,
	input logic header_ack,
	input logic ack,
	input l15_pkg::mem_op_t mem_op,
	input logic mem_valid,
	output l15_pkg::l15_req_t port_req,
	output logic req_ack,
	output logic mem_ready,
	output logic mem_done,
	output l15_pkg::mem_result_t mem_result,
	output logic fetch_valid,
	output l15_pkg::fetch_out_t fetch
);

	// Fetch side of the arbiter
	l15_pkg::l15_req_t fetch_req;
	l15_pkg::l15_rsp_t fetch_rsp;
	logic fetch_hdr_ack;
	logic fetch_outstanding;

	// Data side of the arbiter
	l15_pkg::l15_req_t data_req;
	l15_pkg::l15_rsp_t data_rsp;
	logic data_hdr_ack;
	logic data_ack;
	logic data_pending;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clk(clk),
		.nrst(nrst),
		.grant_rsp(fetch_rsp),
		.grant_hdr_ack(fetch_hdr_ack),
		.req(fetch_req),
		.outstanding(fetch_outstanding),
		.fetch_valid(fetch_valid),
		.fetch(fetch)
	);

	data_access_unit u_data (
		.clk(clk),
		.nrst(nrst),
		.mem_op(mem_op),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.grant_rsp(data_rsp),
		.grant_hdr_ack(data_hdr_ack),
		.grant_ack(data_ack),
		.req(data_req),
		.pending(data_pending),
		.mem_done(mem_done),
		.mem_result(mem_result)
	);

	port_arbiter u_arbiter (
		.clk(clk),
		.nrst(nrst),
		.port_rsp(port_rsp),
		.header_ack(header_ack),
		.ack(ack),
		.req_ack(req_ack),
		.port_req(port_req),
		.fetch_req(fetch_req),
		.fetch_outstanding(fetch_outstanding),
		.fetch_rsp(fetch_rsp),
		.fetch_hdr_ack(fetch_hdr_ack),
		.data_req(data_req),
		.data_pending(data_pending),
		.data_rsp(data_rsp),
		.data_hdr_ack(data_hdr_ack),
		.data_ack(data_ack)
	);

endmodule

/* design/port_arbiter.sv */
`timescale 1ns/1ps

module port_arbiter (
	input logic clk,
	input logic nrst,
	input l15_pkg::l15_rsp_t port_rsp,
	input logic header_ack,
	input logic ack,
	output logic req_ack,
	output l15_pkg::l15_req_t port_req,
	input l15_pkg::l15_req_t fetch_req,
	input logic fetch_outstanding,
	output l15_pkg::l15_rsp_t fetch_rsp,
	output logic fetch_hdr_ack,
	input l15_pkg::l15_req_t data_req,
	input logic data_pending,
	output l15_pkg::l15_rsp_t data_rsp,
	output logic data_hdr_ack,
	output logic data_ack
);

	l15_pkg::owner_t owner;
	logic fetch_rsp_in;
	logic data_finish;

	assign fetch_rsp_in = port_rsp.val && fetch_outstanding;
	// Ack only closes a store
	assign data_finish = data_pending &&
		(port_rsp.val || (ack && data_req.rqtype == l15_pkg::RQ_STORE));

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			owner <= l15_pkg::FETCH_OWNS;
		else
		begin
			case (owner)
				l15_pkg::FETCH_OWNS:
				begin
					if (data_pending)
						owner <= l15_pkg::DATA_WAITS;
				end
				l15_pkg::DATA_WAITS:
				begin
					// Let an in-flight fill return first
					if (!fetch_outstanding || fetch_rsp_in)
						owner <= l15_pkg::DATA_OWNS;
				end
				l15_pkg::DATA_OWNS:
				begin
					if (data_finish)
						owner <= l15_pkg::FETCH_OWNS;
				end
				default:
				begin
					owner <= l15_pkg::FETCH_OWNS;
				end
			endcase
		end
	end

	always_comb
	begin
		port_req = fetch_req;
		if (owner == l15_pkg::DATA_OWNS)
			port_req = data_req;
		else if (owner == l15_pkg::DATA_WAITS)
			port_req.val = 1'b0;

		fetch_rsp = port_rsp;
		data_rsp = port_rsp;
		if (owner == l15_pkg::DATA_OWNS)
			fetch_rsp.val = 1'b0;
		else
			data_rsp.val = 1'b0;
	end

	assign fetch_hdr_ack = header_ack && (owner == l15_pkg::FETCH_OWNS);
	assign data_hdr_ack = header_ack && (owner == l15_pkg::DATA_OWNS);
	assign data_ack = ack && (owner == l15_pkg::DATA_OWNS);

	// Accepted whenever the receiving unit is waiting for it
	assign req_ack = (owner == l15_pkg::DATA_OWNS) ? (port_rsp.val && data_pending) : fetch_rsp_in;

endmodule

/* design/data_access_unit.sv */
`timescale 1ns/1ps

module data_access_unit (
	input logic clk,
	input logic nrst,
	input l15_pkg::mem_op_t mem_op,
	input logic mem_valid,
	output logic mem_ready,
	input l15_pkg::l15_rsp_t grant_rsp,
	input logic grant_hdr_ack,
	input logic grant_ack,
	output l15_pkg::l15_req_t req,
	output logic pending,
	output logic mem_done,
	output l15_pkg::mem_result_t mem_result
);

	localparam logic [1:0] ST_IDLE = 2'b00;
	localparam logic [1:0] ST_REQ = 2'b01;
	localparam logic [1:0] ST_RSP = 2'b10;

	logic [1:0] state;
	l15_pkg::mem_op_t op;
	logic [2:0] size;
	logic misaligned;
	logic [3:0] expect_rt;
	logic finish;
	l15_pkg::xlen_t load_value;

	// Size and alignment from funct3 of the held operation
	always_comb
	begin
		case (op.funct3[1:0])
			2'b00:
			begin
				size = l15_pkg::SIZE_BYTE;
				misaligned = 1'b0;
			end
			2'b01:
			begin
				size = l15_pkg::SIZE_HALF;
				misaligned = op.address[0];
			end
			default:
			begin
				size = l15_pkg::SIZE_WORD;
				misaligned = |op.address[1:0];
			end
		endcase
	end

	assign expect_rt = op.is_store ? l15_pkg::RT_STORE_ACK : l15_pkg::RT_LOAD;
	assign finish = (state == ST_RSP) &&
		((grant_rsp.val && grant_rsp.returntype == expect_rt) || (op.is_store && grant_ack));

	assign mem_ready = (state == ST_IDLE);
	assign pending = (state == ST_REQ && !misaligned) || (state == ST_RSP);

	always_comb
	begin
		req.rqtype = op.is_store ? l15_pkg::RQ_STORE : l15_pkg::RQ_LOAD;
		req.size = size;
		req.address = op.address;
		// Store data copied to every lane of its size
		case (op.funct3[1:0])
			2'b00:
				req.data = {8{op.store_data[7:0]}};
			2'b01:
				req.data = {4{op.store_data[15:0]}};
			default:
				req.data = {2{op.store_data}};
		endcase
		req.val = (state == ST_REQ) && !misaligned;
	end

	load_extract u_extract (
		.data(grant_rsp.data_0),
		.offset(op.address[2:0]),
		.funct3(op.funct3),
		.value(load_value)
	);

	always_ff @(posedge clk)
	begin
		if (mem_valid && mem_ready)
			op <= mem_op;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= ST_IDLE;
			mem_done <= 1'b0;
		end
		else
		begin
			mem_done <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (mem_valid)
						state <= ST_REQ;
				end
				ST_REQ:
				begin
					// A misaligned op never reaches the port
					if (misaligned)
					begin
						state <= ST_IDLE;
						mem_done <= 1'b1;
					end
					else if (grant_hdr_ack)
						state <= ST_RSP;
				end
				ST_RSP:
				begin
					if (finish)
					begin
						state <= ST_IDLE;
						mem_done <= 1'b1;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == ST_REQ && misaligned)
		begin
			mem_result.load_data <= '0;
			mem_result.misaligned <= 1'b1;
		end
		else if (finish)
		begin
			mem_result.load_data <= op.is_store ? '0 : load_value;
			mem_result.misaligned <= 1'b0;
		end
	end

endmodule

/* design/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
	parameter l15_pkg::xlen_t RESET_PC = 32'h0000_0000
) (
	input logic clk,
	input logic nrst,
	input l15_pkg::l15_rsp_t grant_rsp,
	input logic grant_hdr_ack,
	output l15_pkg::l15_req_t req,
	output logic outstanding,
	output logic fetch_valid,
	output l15_pkg::fetch_out_t fetch
);

	// Same encoding as the request-state register of the core
	localparam logic [1:0] ST_IDLE = 2'b00;
	localparam logic [1:0] ST_REQ = 2'b01;
	localparam logic [1:0] ST_RSP = 2'b10;

	logic [1:0] state;
	l15_pkg::xlen_t pc;
	logic rsp_hit;

	assign rsp_hit = grant_rsp.val && (grant_rsp.returntype == l15_pkg::RT_IFILL);
	assign outstanding = (state == ST_RSP);

	// One word fill request for the current pc
	always_comb
	begin
		req.rqtype = l15_pkg::RQ_IFILL;
		req.size = l15_pkg::SIZE_WORD;
		req.address = pc;
		req.data = '0;
		req.val = (state == ST_REQ);
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= ST_IDLE;
			pc <= RESET_PC;
			fetch_valid <= 1'b0;
		end
		else
		begin
			fetch_valid <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					state <= ST_REQ;
				end
				ST_REQ:
				begin
					// Held until the port takes the header
					if (grant_hdr_ack)
						state <= ST_RSP;
				end
				ST_RSP:
				begin
					if (rsp_hit)
					begin
						state <= ST_IDLE;
						pc <= pc + 32'd4;
						fetch_valid <= 1'b1;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Pc bit 2 picks the word inside the doubleword
	always_ff @(posedge clk)
	begin
		if (state == ST_RSP && rsp_hit)
		begin
			fetch.pc <= pc;
			fetch.instr <= pc[2] ? grant_rsp.data_0.instr.upper : grant_rsp.data_0.instr.lower;
		end
	end

endmodule

/* design/load_extract.sv */
`timescale 1ns/1ps

module load_extract (
	input l15_pkg::l15_data_u data,
	input logic [2:0] offset,
	input logic [2:0] funct3,
	output l15_pkg::xlen_t value
);

	l15_pkg::dword_t shifted;

	// Byte k of the doubleword sits at bits 8k+7 down to 8k
	assign shifted = data.raw >> {offset, 3'b000};

	always_comb
	begin
		case (funct3)
			3'b000:
				value = {{24{shifted[7]}}, shifted[7:0]};
			3'b001:
				value = {{16{shifted[15]}}, shifted[15:0]};
			3'b100:
				value = {24'd0, shifted[7:0]};
			3'b101:
				value = {16'd0, shifted[15:0]};
			default:
				value = shifted[31:0];
		endcase
	end

endmodule

/* design/l15_pkg.sv */
package l15_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [63:0] dword_t;

	// Request types, OpenPiton encoding
	localparam logic [4:0] RQ_LOAD = 5'b00000;
	localparam logic [4:0] RQ_STORE = 5'b00001;
	localparam logic [4:0] RQ_IFILL = 5'b10000;

	// Return types, carried as 4 bits inside the core
	localparam logic [3:0] RT_LOAD = 4'b0000;
	localparam logic [3:0] RT_IFILL = 4'b0001;
	localparam logic [3:0] RT_STORE_ACK = 4'b0100;

	// Request sizes
	localparam logic [2:0] SIZE_BYTE = 3'b001;
	localparam logic [2:0] SIZE_HALF = 3'b010;
	localparam logic [2:0] SIZE_WORD = 3'b011;

	typedef struct packed {
		logic [4:0] rqtype;
		logic [2:0] size;
		xlen_t address;
		dword_t data;
		logic val;
	} l15_req_t;

	// Response word seen as two instructions or as one doubleword
	typedef union packed {
		struct packed {
			xlen_t upper;
			xlen_t lower;
		} instr;
		dword_t raw;
	} l15_data_u;

	typedef struct packed {
		logic val;
		logic [3:0] returntype;
		l15_data_u data_0;
	} l15_rsp_t;

	typedef struct packed {
		logic is_store;
		logic [2:0] funct3;
		xlen_t address;
		xlen_t store_data;
	} mem_op_t;

	typedef struct packed {
		xlen_t load_data;
		logic misaligned;
	} mem_result_t;

	typedef struct packed {
		xlen_t pc;
		xlen_t instr;
	} fetch_out_t;

	// Who is connected to the L1.5 port
	typedef enum logic [1:0] {
		FETCH_OWNS = 2'd0,
		DATA_WAITS = 2'd1,
		DATA_OWNS = 2'd2
	} owner_t;

endpackage
